//--- dv/tcip_tb_model.svh
/*
 * testbench model for the tightly coupled IP interface
 * LFSR, address map reference, expected response and compare tasks
 */
`ifndef TCIP_TB_MODEL_SVH
`define TCIP_TB_MODEL_SVH

// 16-bit fibonacci LFSR, taps 16 14 13 11
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    r = {r[30:0], lfsr_q[15]};
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
  end
  return r;
endfunction

// lane i takes lane 3-i
function automatic logic [31:0] swap_lanes(input logic [31:0] w);
  logic [31:0] s;
  for (int i = 0; i < 4; i++)
  begin
    s[8*i +: 8] = w[8*(3-i) +: 8];
  end
  return s;
endfunction

// read data the responder returns for an offset
function automatic logic [31:0] resp_rdata(input logic [15:0] ofs);
  return {~ofs, ofs ^ 16'h5a3c};
endfunction

// clint at 0xE000xxxx, clic at 0xE080xxxx, had image at 0xE4010xxx
function automatic tcip_pkg::tcip_target_e addr_target(input logic [31:0] a);
  if (a[31:16] == 16'hE000)
    return tcip_pkg::tgt_clint;
  if (a[31:16] == 16'hE080)
    return tcip_pkg::tgt_clic;
  if (a[31:12] == 20'hE4010)
    return tcip_pkg::tgt_had_img;
  return tcip_pkg::tgt_none;
endfunction

function automatic tcip_pkg::bmu_resp_t expect_resp(input tcip_pkg::dbus_req_t r,
                                                    input logic dbg, input logic be,
                                                    input logic [31:0] rdata);
  tcip_pkg::bmu_resp_t e;
  e = '0;
  e.trans_cmplt = 1'b1;
  if (!r.supv_mode && !dbg)
  begin
    e.acc_err = 1'b1;
  end
  else
  begin
    e.data_vld = !r.write;
    // writes and unmapped reads return zero
    if (!r.write && addr_target(r.addr) != tcip_pkg::tgt_none)
      e.data = be ? swap_lanes(rdata) : rdata;
  end
  return e;
endfunction

task automatic check_resp(input tcip_pkg::bmu_resp_t got, input tcip_pkg::bmu_resp_t exp);
  if (got !== exp)
  begin
    $display("CHECK FAILED t=%0t bmu_resp got=%h exp=%h", $time, got, exp);
    resp_errs++;
  end
endtask

task automatic check_cmd(input tcip_pkg::ip_cmd_t got, input tcip_pkg::ip_cmd_t exp);
  if (got !== exp)
  begin
    $display("CHECK FAILED t=%0t ip_cmd got=%h exp=%h", $time, got, exp);
    cmd_errs++;
  end
endtask

task automatic check_word(input string name, input logic [tcip_pkg::xlen_w-1:0] got,
                          input logic [tcip_pkg::xlen_w-1:0] exp);
  if (got !== exp)
  begin
    $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    word_errs++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
    bit_errs++;
  end
endtask

`endif

//--- dv/tcip_tb_top.sv
/*
 * testbench for the tightly coupled IP interface
 * drives BMU requests, answers peripheral selects, checks responses
 */
module tcip_tb_top;

  logic                        sel_cpuclk;
  logic                        cpurst_b;
  tcip_pkg::dbus_req_t         dbus_req;
  logic                        dbus_req_vld;
  logic                        dbgon;
  logic                        be_v2;
  tcip_pkg::ip_resp_t          clint_resp;
  tcip_pkg::ip_resp_t          clic_resp;
  tcip_pkg::ip_resp_t          had_img_resp;
  logic                        dbus_grnt;
  tcip_pkg::bmu_resp_t         bmu_resp;
  tcip_pkg::ip_cmd_t           ip_cmd;
  logic                        clint_sel;
  logic                        clic_sel;
  logic                        had_img_sel;
  logic [31:0]                 clic_base;
  logic [15:0]                 lfsr_q = 16'd91;
  int                          resp_errs = 0;
  int                          cmd_errs = 0;
  int                          word_errs = 0;
  int                          bit_errs = 0;
  int                          other_errs = 0;
  tcip_pkg::bmu_resp_t         exp_q[$];

  `include "tcip_tb_model.svh"

  tcip_if_top UUT (.*);

  initial
  begin
    sel_cpuclk = 1'b0;
    forever #5 sel_cpuclk = ~sel_cpuclk;
  end

  // ==============================
  // peripheral responder
  // ==============================
  initial
  begin
    int dly;
    clint_resp   = '0;
    clic_resp    = '0;
    had_img_resp = '0;
    forever
    begin
      @(negedge sel_cpuclk);
      if (clint_sel || clic_sel || had_img_sel)
      begin
        dly = rand_bits(3) % 6;
        repeat (dly) @(posedge sel_cpuclk);
        @(posedge sel_cpuclk);
        if (clint_sel)
          clint_resp <= {1'b1, ip_cmd.write ? 32'h0 : resp_rdata(ip_cmd.offset)};
        if (clic_sel)
          clic_resp <= {1'b1, ip_cmd.write ? 32'h0 : resp_rdata(ip_cmd.offset)};
        if (had_img_sel)
          had_img_resp <= {1'b1, ip_cmd.write ? 32'h0 : resp_rdata(ip_cmd.offset)};
        @(posedge sel_cpuclk);
        clint_resp   <= '0;
        clic_resp    <= '0;
        had_img_resp <= '0;
      end
    end
  end

  // compare every completion against the queued reference
  always @(negedge sel_cpuclk)
  begin
    if (cpurst_b && bmu_resp.trans_cmplt)
    begin
      if (exp_q.size() == 0)
      begin
        $display("completion at t=%0t with no request outstanding", $time);
        other_errs++;
      end
      else
        check_resp(bmu_resp, exp_q.pop_front());
    end
  end

  task automatic wait_grant(output logic ok);
    int n;
    n = 0;
    while (!dbus_grnt && n < 50)
    begin
      @(negedge sel_cpuclk);
      n++;
    end
    ok = dbus_grnt;
    if (!ok)
    begin
      $display("no grant for request at t=%0t", $time);
      other_errs++;
    end
  endtask

  task automatic wait_cmplt();
    int n;
    n = 0;
    while (!bmu_resp.trans_cmplt && n < 30)
    begin
      @(negedge sel_cpuclk);
      n++;
    end
    if (!bmu_resp.trans_cmplt)
    begin
      $display("no completion for granted request at t=%0t", $time);
      other_errs++;
    end
  endtask

  task automatic run_req(input tcip_pkg::dbus_req_t r);
    tcip_pkg::tcip_target_e tgt;
    tcip_pkg::ip_cmd_t      c;
    logic                   ok;
    logic                   drop;
    tgt  = addr_target(r.addr);
    drop = r.acc_deny || r.chk_fail;
    @(posedge sel_cpuclk);
    dbus_req     <= r;
    dbus_req_vld <= 1'b1;
    @(negedge sel_cpuclk);
    wait_grant(ok);
    if (ok && !drop)
      exp_q.push_back(expect_resp(r, dbgon, be_v2, resp_rdata(r.addr[15:0])));
    @(posedge sel_cpuclk);
    dbus_req_vld <= 1'b0;
    @(negedge sel_cpuclk);
    if (drop)
    begin
      repeat (20)
      begin
        check_bit("trans_cmplt", bmu_resp.trans_cmplt, 1'b0);
        check_bit("any_sel", clint_sel | clic_sel | had_img_sel, 1'b0);
        @(negedge sel_cpuclk);
      end
    end
    else if ((!r.supv_mode && !dbgon) || tgt == tcip_pkg::tgt_none)
    begin
      check_bit("trans_cmplt", bmu_resp.trans_cmplt, 1'b1);
      check_bit("any_sel", clint_sel | clic_sel | had_img_sel, 1'b0);
    end
    else
    begin
      check_bit("clint_sel", clint_sel, tgt == tcip_pkg::tgt_clint);
      check_bit("clic_sel", clic_sel, tgt == tcip_pkg::tgt_clic);
      check_bit("had_img_sel", had_img_sel, tgt == tcip_pkg::tgt_had_img);
      c.offset = r.addr[15:0];
      c.wdata  = be_v2 ? swap_lanes(r.wdata) : r.wdata;
      c.write  = r.write;
      c.size   = r.size;
      check_cmd(ip_cmd, c);
      wait_cmplt();
    end
  endtask

  // second request held while the first is open
  task automatic run_pair(input tcip_pkg::dbus_req_t a, input tcip_pkg::dbus_req_t b);
    logic ok;
    int   n;
    @(posedge sel_cpuclk);
    dbus_req     <= a;
    dbus_req_vld <= 1'b1;
    @(negedge sel_cpuclk);
    wait_grant(ok);
    exp_q.push_back(expect_resp(a, dbgon, be_v2, resp_rdata(a.addr[15:0])));
    @(posedge sel_cpuclk);
    dbus_req <= b;
    @(negedge sel_cpuclk);
    n = 0;
    while (!dbus_grnt && n < 30)
    begin
      @(negedge sel_cpuclk);
      n++;
    end
    if (!dbus_grnt)
    begin
      $display("held request never granted at t=%0t", $time);
      other_errs++;
    end
    // grant may only reopen together with the completion
    check_bit("trans_cmplt_at_grant", bmu_resp.trans_cmplt, 1'b1);
    exp_q.push_back(expect_resp(b, dbgon, be_v2, resp_rdata(b.addr[15:0])));
    @(posedge sel_cpuclk);
    dbus_req_vld <= 1'b0;
    @(negedge sel_cpuclk);
    wait_cmplt();
  endtask

  function automatic tcip_pkg::dbus_req_t make_req(input logic [31:0] a, input logic wr,
                                                   input logic supv, input logic deny,
                                                   input logic chk);
    tcip_pkg::dbus_req_t r;
    r.addr      = a;
    r.wdata     = rand_bits(32);
    r.size      = tcip_pkg::bus_size_e'(rand_bits(2) % 3);
    r.write     = wr;
    r.supv_mode = supv;
    r.acc_deny  = deny;
    r.chk_fail  = chk;
    return r;
  endfunction

  // ==============================
  // stimulus
  // ==============================
  initial
  begin
    logic [31:0]         bases [3];
    tcip_pkg::dbus_req_t ureq;
    bases[0]     = 32'hE000_0000;
    bases[1]     = 32'hE080_0000;
    bases[2]     = 32'hE401_0000;
    cpurst_b     = 1'b0;
    dbus_req     = '0;
    dbus_req_vld = 1'b0;
    dbgon        = 1'b0;
    be_v2        = 1'b0;
    repeat (10) @(posedge sel_cpuclk);
    cpurst_b <= 1'b1;
    @(negedge sel_cpuclk);
    check_bit("any_sel", clint_sel | clic_sel | had_img_sel, 1'b0);
    check_bit("trans_cmplt", bmu_resp.trans_cmplt, 1'b0);
    check_bit("data_vld", bmu_resp.data_vld, 1'b0);
    check_bit("acc_err", bmu_resp.acc_err, 1'b0);
    // clic base loads on the first clock out of reset
    @(negedge sel_cpuclk);
    check_word("clic_base", clic_base, 32'hE080_0000);
    for (int pass = 0; pass < 2; pass++)
    begin
      @(posedge sel_cpuclk);
      be_v2 <= pass[0];
      for (int w = 0; w < 3; w++)
      begin
        run_req(make_req(bases[w] | rand_bits(w == 2 ? 12 : 16), 1'b0, 1'b1, 1'b0, 1'b0));
        run_req(make_req(bases[w] | rand_bits(w == 2 ? 12 : 16), 1'b1, 1'b1, 1'b0, 1'b0));
      end
    end
    ureq = make_req(bases[1] | rand_bits(16), 1'b0, 1'b0, 1'b0, 1'b0);
    run_req(ureq);
    @(posedge sel_cpuclk);
    dbgon <= 1'b1;
    run_req(ureq);
    run_req(make_req(32'h1000_0000 | rand_bits(16), 1'b0, 1'b1, 1'b0, 1'b0));
    run_req(make_req(bases[0] | rand_bits(16), 1'b0, 1'b1, 1'b1, 1'b0));
    run_req(make_req(bases[2] | rand_bits(12), 1'b1, 1'b1, 1'b0, 1'b1));
    run_pair(make_req(bases[0] | rand_bits(16), 1'b0, 1'b1, 1'b0, 1'b0),
             make_req(bases[2] | rand_bits(12), 1'b0, 1'b1, 1'b0, 1'b0));
    repeat (5) @(negedge sel_cpuclk);
    if (exp_q.size() != 0)
    begin
      $display("%0d expected completions never arrived", exp_q.size());
      other_errs++;
    end
    $display("errors: resp=%0d cmd=%0d word=%0d bit=%0d other=%0d",
             resp_errs, cmd_errs, word_errs, bit_errs, other_errs);
    if (resp_errs + cmd_errs + word_errs + bit_errs + other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+dv
rtl/tcip_pkg.sv
rtl/tcip_req_decode.sv
rtl/tcip_xfer_track.sv
rtl/tcip_resp_merge.sv
rtl/tcip_if_top.sv
dv/tcip_tb_top.sv

//--- rtl/tcip_if_top.sv
/*
 * tightly coupled IP bus interface top
 * one BMU data master onto CLINT, CLIC and HAD image windows
 */
module tcip_if_top #(
  // clint 0xE000_0000 - 0xE000_FFFF
  parameter logic [15:0] CLINT_BASE   = 16'hE000,
  // clic 0xE080_0000 - 0xE080_FFFF
  parameter logic [15:0] CLIC_BASE    = 16'hE080,
  // had image 0xE401_0000 - 0xE401_0FFF
  parameter logic [19:0] HAD_IMG_BASE = 20'hE4010
) (
  input  logic                        sel_cpuclk,
  input  logic                        cpurst_b,
  input  tcip_pkg::dbus_req_t         dbus_req,
  input  logic                        dbus_req_vld,
  input  logic                        dbgon,
  input  logic                        be_v2,
  input  tcip_pkg::ip_resp_t          clint_resp,
  input  tcip_pkg::ip_resp_t          clic_resp,
  input  tcip_pkg::ip_resp_t          had_img_resp,
  output logic                        dbus_grnt,
  output tcip_pkg::bmu_resp_t         bmu_resp,
  output tcip_pkg::ip_cmd_t           ip_cmd,
  output logic                        clint_sel,
  output logic                        clic_sel,
  output logic                        had_img_sel,
  output logic [tcip_pkg::xlen_w-1:0] clic_base
);

  logic                   accept;
  tcip_pkg::tcip_target_e target;
  logic                   acc_err_req;
  logic                   busy;
  logic                   err_done;
  logic                   dummy_done;
  logic                   rd_pending;

  // ==============================
  // request side
  // ==============================
  tcip_req_decode #(
    .CLINT_BASE   (CLINT_BASE),
    .CLIC_BASE    (CLIC_BASE),
    .HAD_IMG_BASE (HAD_IMG_BASE)
  ) u_req_decode (
    .sel_cpuclk   (sel_cpuclk),
    .cpurst_b     (cpurst_b),
    .dbus_req     (dbus_req),
    .dbus_req_vld (dbus_req_vld),
    .dbgon        (dbgon),
    .busy         (busy),
    .dbus_grnt    (dbus_grnt),
    .accept       (accept),
    .target       (target),
    .acc_err_req  (acc_err_req),
    .clic_base    (clic_base)
  );

  // ==============================
  // outstanding transfer
  // ==============================
  tcip_xfer_track u_xfer_track (
    .sel_cpuclk    (sel_cpuclk),
    .cpurst_b      (cpurst_b),
    .accept        (accept),
    .target        (target),
    .acc_err_req   (acc_err_req),
    .dbus_req      (dbus_req),
    .be_v2         (be_v2),
    .clint_cmplt   (clint_resp.cmplt),
    .clic_cmplt    (clic_resp.cmplt),
    .had_img_cmplt (had_img_resp.cmplt),
    .busy          (busy),
    .clint_sel     (clint_sel),
    .clic_sel      (clic_sel),
    .had_img_sel   (had_img_sel),
    .ip_cmd        (ip_cmd),
    .err_done      (err_done),
    .dummy_done    (dummy_done),
    .rd_pending    (rd_pending)
  );

  // ==============================
  // response side
  // ==============================
  tcip_resp_merge u_resp_merge (
    .clint_resp   (clint_resp),
    .clic_resp    (clic_resp),
    .had_img_resp (had_img_resp),
    .err_done     (err_done),
    .dummy_done   (dummy_done),
    .rd_pending   (rd_pending),
    .be_v2        (be_v2),
    .bmu_resp     (bmu_resp)
  );

endmodule

//--- rtl/tcip_pkg.sv
/*
 * tightly coupled IP interface shared definitions
 * widths, access size and target enums, bus structs and the
 * byte lane swap used for big-endian v2 mode
 */
package tcip_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int xlen_w = 32;
  localparam int ofs_w  = 16;

  // ==============================
  // enums
  // ==============================
  // access size as driven by the BMU
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } bus_size_e;

  // decoded peripheral window
  typedef enum logic [1:0] {
    tgt_none    = 2'b00,
    tgt_clint   = 2'b01,
    tgt_clic    = 2'b10,
    tgt_had_img = 2'b11
  } tcip_target_e;

  // ==============================
  // bus structs
  // ==============================
  // single request from the BMU data side
  typedef struct packed {
    logic [xlen_w-1:0] addr;
    logic [xlen_w-1:0] wdata;
    bus_size_e         size;
    logic              write;
    logic              supv_mode;
    logic              acc_deny;
    logic              chk_fail;
  } dbus_req_t;

  // command shared by all peripherals, qualified by each select
  typedef struct packed {
    logic [ofs_w-1:0]  offset;
    logic [xlen_w-1:0] wdata;
    logic              write;
    bus_size_e         size;
  } ip_cmd_t;

  // one peripheral answer
  typedef struct packed {
    logic              cmplt;
    logic [xlen_w-1:0] rdata;
  } ip_resp_t;

  // answer back to the BMU
  typedef struct packed {
    logic              trans_cmplt;
    logic              data_vld;
    logic              acc_err;
    logic [xlen_w-1:0] data;
  } bmu_resp_t;

  // reverse the four byte lanes of a word
  function automatic logic [xlen_w-1:0] byte_swap(input logic [xlen_w-1:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

//--- rtl/tcip_req_decode.sv
/*
 * request decode
 * grants BMU requests when idle, checks privilege and
 * maps the address onto the CLINT, CLIC and HAD image windows
 */
module tcip_req_decode #(
  parameter logic [15:0] CLINT_BASE   = 16'hE000,
  parameter logic [15:0] CLIC_BASE    = 16'hE080,
  parameter logic [19:0] HAD_IMG_BASE = 20'hE4010
) (
  input  logic                        sel_cpuclk,
  input  logic                        cpurst_b,
  input  tcip_pkg::dbus_req_t         dbus_req,
  input  logic                        dbus_req_vld,
  input  logic                        dbgon,
  input  logic                        busy,
  output logic                        dbus_grnt,
  output logic                        accept,
  output tcip_pkg::tcip_target_e      target,
  output logic                        acc_err_req,
  output logic [tcip_pkg::xlen_w-1:0] clic_base
);

  logic                        clint_hit;
  logic                        clic_hit;
  logic                        had_img_hit;
  logic [tcip_pkg::xlen_w-1:0] clic_base_q;

  // ==============================
  // grant and accept
  // ==============================
  // grant is combinational, only one transaction in flight
  assign dbus_grnt = dbus_req_vld && !busy;

  // denied or check-failed requests are granted and dropped
  assign accept = dbus_grnt
               && !dbus_req.acc_deny
               && !dbus_req.chk_fail;

  // user mode outside debug has no access to these windows
  assign acc_err_req = !dbus_req.supv_mode && !dbgon;

  // ==============================
  // address map
  // ==============================
  // clint and clic own 64KB each, the had image 4KB
  assign clint_hit   = (dbus_req.addr[31:16] == CLINT_BASE);
  assign clic_hit    = (dbus_req.addr[31:16] == CLIC_BASE);
  assign had_img_hit = (dbus_req.addr[31:12] == HAD_IMG_BASE);

  always_comb
  begin
    target = tcip_pkg::tgt_none;
    if (clint_hit)
    begin
      target = tcip_pkg::tgt_clint;
    end
    else if (clic_hit)
    begin
      target = tcip_pkg::tgt_clic;
    end
    else if (had_img_hit)
    begin
      target = tcip_pkg::tgt_had_img;
    end
  end

  // ==============================
  // clic base report
  // ==============================
  // base becomes visible on the first clock out of reset
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      clic_base_q <= '0;
    end
    else
    begin
      clic_base_q <= {CLIC_BASE, 16'h0000};
    end
  end

  assign clic_base = clic_base_q;

endmodule

//--- rtl/tcip_resp_merge.sv
/*
 * response merge
 * folds the peripheral completions, error and dummy
 * completions into the single BMU response
 */
module tcip_resp_merge (
  input  tcip_pkg::ip_resp_t  clint_resp,
  input  tcip_pkg::ip_resp_t  clic_resp,
  input  tcip_pkg::ip_resp_t  had_img_resp,
  input  logic                err_done,
  input  logic                dummy_done,
  input  logic                rd_pending,
  input  logic                be_v2,
  output tcip_pkg::bmu_resp_t bmu_resp
);

  logic                        ip_cmplt;
  logic [tcip_pkg::xlen_w-1:0] rd_mux;
  logic [tcip_pkg::xlen_w-1:0] rd_data;

  // ==============================
  // read data
  // ==============================
  // only the completing peripheral contributes
  // dummy and error completions read back zero
  assign rd_mux = {tcip_pkg::xlen_w{clint_resp.cmplt}}   & clint_resp.rdata
                | {tcip_pkg::xlen_w{clic_resp.cmplt}}    & clic_resp.rdata
                | {tcip_pkg::xlen_w{had_img_resp.cmplt}} & had_img_resp.rdata;

  // big-endian v2 swaps lanes on the way back as well
  assign rd_data = be_v2 ? tcip_pkg::byte_swap(rd_mux) : rd_mux;

  // ==============================
  // completion flags
  // ==============================
  assign ip_cmplt = clint_resp.cmplt
                 || clic_resp.cmplt
                 || had_img_resp.cmplt;

  assign bmu_resp.trans_cmplt = ip_cmplt || err_done || dummy_done;

  // writes and access errors carry no data
  assign bmu_resp.data_vld = (ip_cmplt || dummy_done) && rd_pending;

  assign bmu_resp.acc_err = err_done;

  assign bmu_resp.data = rd_data;

endmodule

//--- rtl/tcip_xfer_track.sv
/*
 * transaction tracker
 * holds the single outstanding transfer, drives the peripheral
 * selects and command, and flags error and dummy completions
 */
module tcip_xfer_track (
  input  logic                   sel_cpuclk,
  input  logic                   cpurst_b,
  input  logic                   accept,
  input  tcip_pkg::tcip_target_e target,
  input  logic                   acc_err_req,
  input  tcip_pkg::dbus_req_t    dbus_req,
  input  logic                   be_v2,
  input  logic                   clint_cmplt,
  input  logic                   clic_cmplt,
  input  logic                   had_img_cmplt,
  output logic                   busy,
  output logic                   clint_sel,
  output logic                   clic_sel,
  output logic                   had_img_sel,
  output tcip_pkg::ip_cmd_t      ip_cmd,
  output logic                   err_done,
  output logic                   dummy_done,
  output logic                   rd_pending
);

  logic                        req_ok;
  logic [2:0]                  tgt_vec;
  logic [2:0]                  cmplt_vec;
  logic [2:0]                  sel_q;
  logic [tcip_pkg::ofs_w-1:0]  ofs_q;
  tcip_pkg::bus_size_e         size_q;
  logic                        write_q;

  // accepted and allowed through to a window or the dummy slot
  assign req_ok = accept && !acc_err_req;

  // had image, clic, clint from msb down
  assign tgt_vec   = {target == tcip_pkg::tgt_had_img,
                      target == tcip_pkg::tgt_clic,
                      target == tcip_pkg::tgt_clint};
  assign cmplt_vec = {had_img_cmplt, clic_cmplt, clint_cmplt};

  // ==============================
  // selects and completions
  // ==============================
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      sel_q      <= 3'b000;
      err_done   <= 1'b0;
      dummy_done <= 1'b0;
      write_q    <= 1'b0;
    end
    else
    begin
      // a new accept may land in the completion cycle
      if (req_ok)
      begin
        sel_q   <= tgt_vec;
        write_q <= dbus_req.write;
      end
      else
      begin
        sel_q <= sel_q & ~cmplt_vec;
      end
      err_done   <= accept && acc_err_req;
      dummy_done <= req_ok && (target == tcip_pkg::tgt_none);
    end
  end

  // offset and size of the open transfer
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ofs_q  <= '0;
      size_q <= tcip_pkg::size_byte;
    end
    else if (req_ok)
    begin
      ofs_q  <= dbus_req.addr[tcip_pkg::ofs_w-1:0];
      size_q <= dbus_req.size;
    end
  end

  assign clint_sel   = sel_q[0];
  assign clic_sel    = sel_q[1];
  assign had_img_sel = sel_q[2];

  // hold off the BMU until the selected peripheral answers
  assign busy       = |(sel_q & ~cmplt_vec);
  assign rd_pending = !write_q;

  // ==============================
  // peripheral command
  // ==============================
  // BMU keeps wdata stable while the transfer is open
  assign ip_cmd.offset = ofs_q;
  assign ip_cmd.wdata  = be_v2 ? tcip_pkg::byte_swap(dbus_req.wdata) : dbus_req.wdata;
  assign ip_cmd.write  = write_q;
  assign ip_cmd.size   = size_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module tcip_tb_top \
  -f filelist.f \
  -o tcip_sim

./obj_dir/tcip_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
  exit 0
fi
exit 1
